// File: common/csr_pkg.sv
// Shared definitions for the machine-mode CSR unit
// Widths, CSR addresses, identification constants,
// access opcode and privilege enums, mstatus layout

package csr_pkg;

    ////////////////////
    // Widths

    localparam int XLEN       = 32;
    localparam int COUNTER_W  = 64;
    localparam int CSR_ADDR_W = 12;
    localparam int ECODE_W    = 5;
    localparam int RETIRE_W   = 2;

    ////////////////////
    // Enums

    // Low two bits of the funct3 field
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } privilege_e;

    ////////////////////
    // mstatus layout

    // Only the machine interrupt enable stack is kept
    typedef struct packed {
        logic [18:0] zero_hi;
        privilege_e  mpp;
        logic [2:0]  zero_mid_hi;
        logic        mpie;
        logic [2:0]  zero_mid_lo;
        logic        mie;
        logic [2:0]  zero_lo;
    } mstatus_t;

    // mie, mpie and mpp
    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h0000_1888;

    ////////////////////
    // CSR addresses

    // Machine information, read-only range
    localparam logic [CSR_ADDR_W-1:0] ADDR_MVENDORID = 12'hF11;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MARCHID   = 12'hF12;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID    = 12'hF13;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID   = 12'hF14;

    // Machine trap setup and handling
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MISA     = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL    = 12'h343;

    // Machine counters
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRET  = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLEH   = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRETH = 12'hB82;

    // User read aliases
    localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLE    = 12'hC00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TIME     = 12'hC01;
    localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRET  = 12'hC02;
    localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLEH   = 12'hC80;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TIMEH    = 12'hC81;
    localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRETH = 12'hC82;

    ////////////////////
    // Constant register contents

    // MXL = 1 (32-bit), extensions I and U
    localparam logic [XLEN-1:0] MISA_VALUE   = 32'h4010_0100;
    localparam logic [XLEN-1:0] MIMPID_VALUE = 32'h0000_0001;
    localparam logic [XLEN-1:0] HART_ID      = 32'h0000_0000;

endpackage

// File: common/csr_bus_if.sv
// Register bus between the access logic and one register block
// Access side drives address, write strobe and write data
// Block side answers with read data and an address hit

interface csr_bus_if;
    import csr_pkg::*;

    logic [CSR_ADDR_W-1:0] addr;
    logic                  write;
    logic [XLEN-1:0]       wdata;
    logic [XLEN-1:0]       rdata;
    logic                  hit;

    modport access (
        output addr,
        output write,
        output wdata,
        input  rdata,
        input  hit
    );

    // Block decodes its own addresses
    modport block (
        input  addr,
        input  write,
        input  wdata,
        output rdata,
        output hit
    );

endinterface

// File: logic/csr_access.sv
// CSR access control
// Legality check, read-modify-write evaluation,
// write strobe to the register blocks and registered response

module csr_access (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
    input  csr_pkg::csr_op_e               csr_op,
    input  logic [csr_pkg::XLEN-1:0]       rs1,
    input  csr_pkg::privilege_e            privilege,
    output logic                           rsp_valid,
    output logic                           illegal,
    output logic [csr_pkg::XLEN-1:0]       rdata,
    csr_bus_if.access                      trap_bus,
    csr_bus_if.access                      cnt_bus
);
    import csr_pkg::*;

    logic            any_hit;
    logic            priv_ok;
    logic            read_only;
    logic            is_write;
    logic            legal;
    logic            commit;
    logic [XLEN-1:0] old_value;
    logic [XLEN-1:0] new_value;

    ////////////////////
    // Address and read merge

    assign trap_bus.addr = csr_addr;
    assign cnt_bus.addr  = csr_addr;

    // Blocks decode disjoint ranges, at most one hits
    assign any_hit = trap_bus.hit | cnt_bus.hit;

    always_comb begin
        if (trap_bus.hit) begin
            old_value = trap_bus.rdata;
        end else if (cnt_bus.hit) begin
            old_value = cnt_bus.rdata;
        end else begin
            old_value = '0;
        end
    end

    ////////////////////
    // Legality

    // Bits 9:8 give the lowest privilege allowed to touch the CSR
    assign priv_ok   = (csr_addr[9:8] <= privilege);
    assign read_only = &csr_addr[11:10];

    // Set and clear with rs1 of zero only read
    assign is_write = (csr_op == CSR_RW) || (rs1 != '0);

    assign legal  = any_hit && priv_ok && !(is_write && read_only);
    assign commit = req && legal && is_write;

    ////////////////////
    // New value

    always_comb begin
        case (csr_op)
            CSR_RW:  new_value = rs1;
            CSR_RS:  new_value = old_value | rs1;
            CSR_RC:  new_value = old_value & ~rs1;
            default: new_value = rs1;
        endcase
    end

    assign trap_bus.write = commit;
    assign trap_bus.wdata = new_value;
    assign cnt_bus.write  = commit;
    assign cnt_bus.wdata  = new_value;

    ////////////////////
    // Response

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            rsp_valid <= req;
            illegal   <= req && !legal;
        end
    end

    // Old value, zero for a rejected access
    always_ff @(posedge clk) begin
        if (req) begin
            rdata <= legal ? old_value : '0;
        end
    end

    // One response per request, one cycle later
    a_rsp_follows_req: assert property (
        @(posedge clk) disable iff (rst) req |=> rsp_valid
    );

    a_rsp_needs_req: assert property (
        @(posedge clk) disable iff (rst) rsp_valid |-> $past(req)
    );

    // The write strobe lands in exactly one block
    a_write_single_block: assert property (
        @(posedge clk) disable iff (rst) commit |-> (trap_bus.hit ^ cnt_bus.hit)
    );

endmodule

// File: trap/trap_regs.sv
// Machine trap state
// Privilege level, mstatus, mtvec, mepc, mcause, mtval, mscratch
// Trap entry and mret sequencing
// Constant identification registers

module trap_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        trap,
    input  logic [csr_pkg::ECODE_W-1:0] trap_code,
    input  logic [csr_pkg::XLEN-1:0]    trap_pc,
    input  logic [csr_pkg::XLEN-1:0]    trap_tval,
    input  logic                        mret,
    output logic [csr_pkg::XLEN-1:0]    trap_vector,
    output logic [csr_pkg::XLEN-1:0]    epc,
    output csr_pkg::privilege_e         privilege,
    csr_bus_if.block                    bus
);
    import csr_pkg::*;

    mstatus_t             mstatus;
    mstatus_t             mstatus_wr;
    logic [XLEN-1:0]      mtvec;
    logic [XLEN-1:0]      mepc;
    logic                 mcause_irq;
    logic [ECODE_W-1:0]   mcause_code;
    logic [XLEN-1:0]      mtval;
    logic [XLEN-1:0]      mscratch;
    logic                 wr_en;

    assign wr_en = bus.write && bus.hit;

    ////////////////////
    // Privilege and mstatus

    // mpp holds only user or machine, anything else reads back as user
    always_comb begin
        mstatus_wr = mstatus_t'(bus.wdata & MSTATUS_MASK);
        if (mstatus_wr.mpp != PRIV_MACHINE) begin
            mstatus_wr.mpp = PRIV_USER;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            privilege   <= PRIV_MACHINE;
            mstatus     <= '0;
            mstatus.mpp <= PRIV_MACHINE;
        end else if (trap) begin
            privilege    <= PRIV_MACHINE;
            mstatus.mpp  <= privilege;
            mstatus.mpie <= mstatus.mie;
            mstatus.mie  <= 1'b0;
        end else if (mret) begin
            privilege    <= mstatus.mpp;
            mstatus.mpp  <= PRIV_USER;
            mstatus.mie  <= mstatus.mpie;
            mstatus.mpie <= 1'b1;
        end else if (wr_en && bus.addr == ADDR_MSTATUS) begin
            mstatus <= mstatus_wr;
        end
    end

    ////////////////////
    // Trap vector and return address

    // Direct mode only
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec <= '0;
        end else if (wr_en && bus.addr == ADDR_MTVEC) begin
            mtvec <= {bus.wdata[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc <= '0;
        end else if (trap) begin
            mepc <= {trap_pc[XLEN-1:2], 2'b00};
        end else if (wr_en && bus.addr == ADDR_MEPC) begin
            mepc <= {bus.wdata[XLEN-1:2], 2'b00};
        end
    end

    assign trap_vector = mtvec;
    assign epc         = mepc;

    ////////////////////
    // Cause, value, scratch

    // Traps here are always exceptions
    always_ff @(posedge clk) begin
        if (rst) begin
            mcause_irq  <= 1'b0;
            mcause_code <= '0;
            mtval       <= '0;
            mscratch    <= '0;
        end else begin
            if (trap) begin
                mcause_irq  <= 1'b0;
                mcause_code <= trap_code;
                mtval       <= trap_tval;
            end else if (wr_en && bus.addr == ADDR_MCAUSE) begin
                mcause_irq  <= bus.wdata[XLEN-1];
                mcause_code <= bus.wdata[ECODE_W-1:0];
            end else if (wr_en && bus.addr == ADDR_MTVAL) begin
                mtval <= bus.wdata;
            end
            if (wr_en && bus.addr == ADDR_MSCRATCH) begin
                mscratch <= bus.wdata;
            end
        end
    end

    ////////////////////
    // Read decode

    // misa is WARL here, writes are accepted and dropped
    always_comb begin
        bus.hit = 1'b1;
        case (bus.addr)
            ADDR_MISA:      bus.rdata = MISA_VALUE;
            ADDR_MVENDORID: bus.rdata = '0;
            ADDR_MARCHID:   bus.rdata = '0;
            ADDR_MIMPID:    bus.rdata = MIMPID_VALUE;
            ADDR_MHARTID:   bus.rdata = HART_ID;
            ADDR_MSTATUS:   bus.rdata = mstatus;
            ADDR_MTVEC:     bus.rdata = mtvec;
            ADDR_MSCRATCH:  bus.rdata = mscratch;
            ADDR_MEPC:      bus.rdata = mepc;
            ADDR_MCAUSE:    bus.rdata = {mcause_irq, {(XLEN-ECODE_W-1){1'b0}}, mcause_code};
            ADDR_MTVAL:     bus.rdata = mtval;
            default: begin
                bus.hit   = 1'b0;
                bus.rdata = '0;
            end
        endcase
    end

    a_trap_mret_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(trap && mret)
    );

endmodule

// File: logic/csr_counters.sv
// Cycle and retired-instruction counters
// 64-bit mcycle and minstret with separately writable halves
// User read aliases cycle, time and instret

module csr_counters (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [csr_pkg::RETIRE_W-1:0] retire_inc,
    csr_bus_if.block                     bus
);
    import csr_pkg::*;

    logic [COUNTER_W-1:0] mcycle;
    logic [COUNTER_W-1:0] minstret;
    logic [COUNTER_W-1:0] mcycle_next;
    logic [COUNTER_W-1:0] minstret_next;
    logic                 wr_en;

    assign wr_en = bus.write && bus.hit;

    assign mcycle_next   = mcycle + COUNTER_W'(1);
    assign minstret_next = minstret + COUNTER_W'(retire_inc);

    ////////////////////
    // Counter update

    // Write selects per half after the add, so the carry still
    // reaches an unwritten upper half
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle[XLEN-1:0] <= (wr_en && bus.addr == ADDR_MCYCLE) ?
                bus.wdata : mcycle_next[XLEN-1:0];
            mcycle[COUNTER_W-1:XLEN] <= (wr_en && bus.addr == ADDR_MCYCLEH) ?
                bus.wdata[COUNTER_W-XLEN-1:0] : mcycle_next[COUNTER_W-1:XLEN];
            minstret[XLEN-1:0] <= (wr_en && bus.addr == ADDR_MINSTRET) ?
                bus.wdata : minstret_next[XLEN-1:0];
            minstret[COUNTER_W-1:XLEN] <= (wr_en && bus.addr == ADDR_MINSTRETH) ?
                bus.wdata[COUNTER_W-XLEN-1:0] : minstret_next[COUNTER_W-1:XLEN];
        end
    end

    ////////////////////
    // Read decode

    // No separate timer, time follows mcycle
    always_comb begin
        bus.hit = 1'b1;
        case (bus.addr)
            ADDR_MCYCLE, ADDR_CYCLE, ADDR_TIME:
                bus.rdata = mcycle[XLEN-1:0];
            ADDR_MCYCLEH, ADDR_CYCLEH, ADDR_TIMEH:
                bus.rdata = mcycle[COUNTER_W-1:XLEN];
            ADDR_MINSTRET, ADDR_INSTRET:
                bus.rdata = minstret[XLEN-1:0];
            ADDR_MINSTRETH, ADDR_INSTRETH:
                bus.rdata = minstret[COUNTER_W-1:XLEN];
            default: begin
                bus.hit   = 1'b0;
                bus.rdata = '0;
            end
        endcase
    end

    a_mcycle_monotonic: assert property (
        @(posedge clk) disable iff (rst) !wr_en |=> mcycle > $past(mcycle)
    );

    a_minstret_monotonic: assert property (
        @(posedge clk) disable iff (rst) !wr_en |=> minstret >= $past(minstret)
    );

endmodule

// File: logic/csr_unit.sv
// CSR unit top level
// Access logic with the trap register block and the counter block

module csr_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
    input  csr_pkg::csr_op_e               csr_op,
    input  logic [csr_pkg::XLEN-1:0]       rs1,
    input  logic                           trap,
    input  logic [csr_pkg::ECODE_W-1:0]    trap_code,
    input  logic [csr_pkg::XLEN-1:0]       trap_pc,
    input  logic [csr_pkg::XLEN-1:0]       trap_tval,
    input  logic                           mret,
    input  logic [csr_pkg::RETIRE_W-1:0]   retire_inc,
    output logic                           rsp_valid,
    output logic                           illegal,
    output logic [csr_pkg::XLEN-1:0]       rdata,
    output logic [csr_pkg::XLEN-1:0]       trap_vector,
    output logic [csr_pkg::XLEN-1:0]       epc,
    output csr_pkg::privilege_e            privilege
);

    // One bus per register block
    csr_bus_if trap_bus ();
    csr_bus_if cnt_bus ();

    csr_access i_csr_access (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .csr_addr  (csr_addr),
        .csr_op    (csr_op),
        .rs1       (rs1),
        .privilege (privilege),
        .rsp_valid (rsp_valid),
        .illegal   (illegal),
        .rdata     (rdata),
        .trap_bus  (trap_bus.access),
        .cnt_bus   (cnt_bus.access)
    );

    trap_regs i_trap_regs (
        .clk         (clk),
        .rst         (rst),
        .trap        (trap),
        .trap_code   (trap_code),
        .trap_pc     (trap_pc),
        .trap_tval   (trap_tval),
        .mret        (mret),
        .trap_vector (trap_vector),
        .epc         (epc),
        .privilege   (privilege),
        .bus         (trap_bus.block)
    );

    csr_counters i_csr_counters (
        .clk        (clk),
        .rst        (rst),
        .retire_inc (retire_inc),
        .bus        (cnt_bus.block)
    );

endmodule

// File: dv/csr_checker.sv
// Response checker and reference model for the CSR unit
// Models privilege, mpp, mtvec and mepc, counts errors

module csr_checker (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
    input  csr_pkg::csr_op_e               csr_op,
    input  logic [csr_pkg::XLEN-1:0]       rs1,
    input  logic                           trap,
    input  logic [csr_pkg::XLEN-1:0]       trap_pc,
    input  logic                           mret,
    input  logic                           rsp_valid,
    input  logic                           illegal,
    input  logic [csr_pkg::XLEN-1:0]       rdata,
    input  logic [csr_pkg::XLEN-1:0]       trap_vector,
    input  logic [csr_pkg::XLEN-1:0]       epc,
    input  csr_pkg::privilege_e            privilege,
    input  logic [csr_pkg::XLEN-1:0]       exp_rdata,
    input  logic                           exp_illegal,
    input  logic [1:0]                     exp_mode,
    output int                             value_errors,
    output int                             other_errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import csr_pkg::*;

    logic [1:0]      m_priv;
    logic [1:0]      m_mpp;
    logic [1:0]      mpp_next;
    logic [XLEN-1:0] mstatus_next;
    logic [XLEN-1:0] m_mtvec;
    logic [XLEN-1:0] m_mepc;
    logic            pending;
    logic [XLEN-1:0] pend_rdata;
    logic            pend_illegal;
    logic [1:0]      pend_mode;
    logic [XLEN-1:0] base;
    logic            is_write;

    function automatic logic [31:0] apply_op(input logic [31:0] old, input csr_op_e op,
                                             input logic [31:0] v);
        case (op)
            CSR_RS:  return old | v;
            CSR_RC:  return old & ~v;
            default: return v;
        endcase
    endfunction

    assign is_write = (csr_op == CSR_RW) || (rs1 != '0);

    always_comb begin
        mstatus_next = apply_op({19'd0, m_mpp, 11'd0}, csr_op, rs1);
        mpp_next     = mstatus_next[12:11];
        if (mpp_next != 2'd3) begin
            mpp_next = 2'd0;
        end
    end

    ////////////////////
    // Reference model

    always @(posedge clk) begin
        if (rst) begin
            m_priv  <= 2'd3;
            m_mpp   <= 2'd3;
            m_mtvec <= '0;
            m_mepc  <= '0;
            pending <= 1'b0;
        end else begin
            pending      <= req;
            pend_rdata   <= exp_rdata;
            pend_illegal <= exp_illegal;
            pend_mode    <= exp_mode;
            if (trap) begin
                m_priv <= 2'd3;
                m_mpp  <= m_priv;
                m_mepc <= trap_pc & 32'hFFFF_FFFC;
            end else if (mret) begin
                m_priv <= m_mpp;
                m_mpp  <= 2'd0;
            end else if (req && is_write && m_priv == 2'd3) begin
                // Machine CSRs 0x3xx need machine privilege
                if (csr_addr == ADDR_MSTATUS) begin
                    m_mpp <= mpp_next;
                end else if (csr_addr == ADDR_MTVEC) begin
                    m_mtvec <= apply_op(m_mtvec, csr_op, rs1) & 32'hFFFF_FFFC;
                end else if (csr_addr == ADDR_MEPC) begin
                    m_mepc <= apply_op(m_mepc, csr_op, rs1) & 32'hFFFF_FFFC;
                end
            end
        end
    end

    ////////////////////
    // Comparison

    initial begin
        value_errors = 0;
        other_errors = 0;
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (pending && !rsp_valid) begin
                $display("Response missing one cycle after a request at time %0t", $time);
                other_errors++;
            end else if (!pending && rsp_valid) begin
                $display("Response appeared without a request at time %0t", $time);
                other_errors++;
            end else if (pending) begin
                if (illegal !== pend_illegal) begin
                    $display("Fail %0t: illegal %b, expected %b", $time, illegal, pend_illegal);
                    value_errors++;
                end
                if (pend_mode == 2'd0 && rdata !== pend_rdata) begin
                    $display("Fail %0t: rdata %h, expected %h", $time, rdata, pend_rdata);
                    value_errors++;
                end
                if (pend_mode == 2'd2 && (rdata - base) !== pend_rdata) begin
                    $display("Fail %0t: counter moved by %0d, expected %0d", $time,
                             rdata - base, pend_rdata);
                    value_errors++;
                end
                base = rdata;
            end
            if (trap_vector !== m_mtvec) begin
                $display("Fail %0t: trap_vector %h, expected %h", $time, trap_vector, m_mtvec);
                value_errors++;
            end
            if (epc !== m_mepc) begin
                $display("Fail %0t: epc %h, expected %h", $time, epc, m_mepc);
                value_errors++;
            end
            if (2'(privilege) !== m_priv) begin
                $display("Fail %0t: privilege %0d, expected %0d", $time, privilege, m_priv);
                value_errors++;
            end
        end
    end

endmodule

// File: dv/tb_csr_unit.sv
// Testbench top for the CSR unit
// Clock, reset, stimulus file reader, driver and watchdog

module tb_csr_unit;
    timeunit 1ns;
    timeprecision 1ps;
    import csr_pkg::*;

    logic                  clk;
    logic                  rst;
    logic                  req;
    logic [CSR_ADDR_W-1:0] csr_addr;
    csr_op_e               csr_op;
    logic [XLEN-1:0]       rs1;
    logic                  trap;
    logic [ECODE_W-1:0]    trap_code;
    logic [XLEN-1:0]       trap_pc;
    logic [XLEN-1:0]       trap_tval;
    logic                  mret;
    logic [RETIRE_W-1:0]   retire_inc;
    logic                  rsp_valid;
    logic                  illegal;
    logic [XLEN-1:0]       rdata;
    logic [XLEN-1:0]       trap_vector;
    logic [XLEN-1:0]       epc;
    privilege_e            privilege;

    // Expected response for the checker
    logic [XLEN-1:0] exp_rdata;
    logic            exp_illegal;
    logic [1:0]      exp_mode;
    int              value_errors;
    int              other_errors;

    logic [31:0] lfsr_state;
    logic [31:0] sh_scratch;
    logic [31:0] sh_tvec;
    int          line_count;

    csr_unit i_csr_unit (.*);

    csr_checker csr_checker (.*);

    always #5 clk = ~clk;

    ////////////////////
    // Helpers

    // Galois LFSR, one step per bit
    function automatic logic [31:0] draw_word();
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) :
                (lfsr_state >> 1);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] apply_op(input logic [31:0] old, input logic [1:0] op,
                                             input logic [31:0] v);
        case (op)
            2'd2:    return old | v;
            2'd3:    return old & ~v;
            default: return v;
        endcase
    endfunction

    // Track mscratch and mtvec for legal machine writes
    task automatic update_shadow(input logic [11:0] a, input logic [1:0] op,
                                 input logic [31:0] v);
        if (op == 2'd1 || v != 0) begin
            if (a == ADDR_MSCRATCH) begin
                sh_scratch = apply_op(sh_scratch, op, v);
            end else if (a == ADDR_MTVEC) begin
                sh_tvec = apply_op(sh_tvec, op, v) & 32'hFFFF_FFFC;
            end
        end
    endtask

    task automatic access(input logic [11:0] a, input logic [1:0] op, input logic [31:0] v,
                          input logic [31:0] er, input logic [1:0] mode, input logic ei);
        int waited;
        csr_addr    = a;
        csr_op      = csr_op_e'(op);
        rs1         = v;
        exp_rdata   = er;
        exp_illegal = ei;
        exp_mode    = mode;
        req         = 1'b1;
        @(negedge clk);
        req    = 1'b0;
        waited = 0;
        while (!rsp_valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!rsp_valid) begin
            $display("No response arrived for the access to address %h", a);
        end
    endtask

    ////////////////////
    // Stimulus

    initial begin
        int          fd;
        int          n;
        logic [7:0]  cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        string       text;
        clk = 0;
        rst = 1;
        req = 0;
        csr_addr = '0;
        csr_op = CSR_RW;
        rs1 = '0;
        trap = 0;
        trap_code = '0;
        trap_pc = '0;
        trap_tval = '0;
        mret = 0;
        retire_inc = '0;
        exp_rdata = '0;
        exp_illegal = 0;
        exp_mode = '0;
        lfsr_state = 32'd61901;
        sh_scratch = '0;
        sh_tvec = '0;
        line_count = 0;
        fd = $fopen("dv/csr_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Stimulus file dv/csr_stimulus.txt could not be opened");
            $display("TB FAILED");
            $finish;
        end else begin
            while ($fgets(text, fd) > 0) begin
                line_count++;
            end
            $fclose(fd);
            fd = $fopen("dv/csr_stimulus.txt", "r");
            repeat (3) @(negedge clk);
            rst = 0;
            while ($fscanf(fd, " %c", cmd) == 1) begin
                case (cmd)
                    "#": n = $fgets(text, fd);
                    "R": begin
                        n = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                        access(a[11:0], b[1:0], c, d, (e == 2) ? 2'd1 : 2'd0, e == 1);
                        if (e != 1) begin
                            update_shadow(a[11:0], b[1:0], c);
                        end
                    end
                    "S": begin
                        n = $fscanf(fd, "%h %h", a, b);
                        c = draw_word();
                        access(a[11:0], b[1:0], c,
                               (a[11:0] == ADDR_MTVEC) ? sh_tvec : sh_scratch, 2'd0, 1'b0);
                        update_shadow(a[11:0], b[1:0], c);
                    end
                    "T": begin
                        n = $fscanf(fd, "%h %h %h", a, b, c);
                        trap_code = a[ECODE_W-1:0];
                        trap_pc   = b;
                        trap_tval = c;
                        trap      = 1'b1;
                        @(negedge clk);
                        trap = 1'b0;
                    end
                    "M": begin
                        mret = 1'b1;
                        @(negedge clk);
                        mret = 1'b0;
                    end
                    "I": begin
                        n = $fscanf(fd, "%h %d", a, b);
                        retire_inc = a[RETIRE_W-1:0];
                        repeat (b) @(negedge clk);
                    end
                    "D": begin
                        // Two reads with b idle cycles between them
                        n = $fscanf(fd, "%h %h %d", a, b, c);
                        retire_inc = b[RETIRE_W-1:0];
                        access(a[11:0], 2'd2, '0, '0, 2'd1, 1'b0);
                        repeat (c) @(negedge clk);
                        d = (a[11:0] == ADDR_MCYCLE) ? c + 1 : b * (c + 1);
                        access(a[11:0], 2'd2, '0, d, 2'd2, 1'b0);
                    end
                    default: $display("Unknown stimulus command %c", cmd);
                endcase
            end
            $fclose(fd);
            repeat (2) @(negedge clk);
            $display("Errors: %0d value, %0d protocol", value_errors, other_errors);
            if (value_errors == 0 && other_errors == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

    // Watchdog
    initial begin
        #1;
        wait (line_count > 0);
        #((line_count * 20 + 100) * 10);
        $display("Simulation timed out before the stimulus finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: dv/csr_stimulus.txt
# R addr op rs1 rdata illegal(2 = legal, rdata unchecked) | S addr op | T code pc tval
# M | I retire count | D addr retire idle_cycles ; op 1 rw, 2 set, 3 clear
R 300 2 0 1800 0
R 301 2 0 40100100 0
R F13 2 0 1 0
R F14 2 0 0 0
R B03 2 0 0 1
R 340 1 12345678 0 0
R 340 2 0 12345678 0
S 340 2
S 340 3
R 305 1 107 0 0
R 305 2 0 104 0
S 305 2
S 305 3
S 305 1
R 300 2 8 1800 0
T 2 80000103 deadbeef
R 341 2 0 80000100 0
R 342 2 0 2 0
R 343 2 0 deadbeef 0
R 300 2 0 1880 0
R 300 3 1800 1880 0
M
R 340 2 0 0 1
R 340 1 55 0 1
R C00 2 0 0 2
T 8 1000 0
S 340 2
R 301 1 0 40100100 0
R 301 2 0 40100100 0
R C00 1 5 0 1
R F14 1 5 0 1
I 0 2
R B00 1 fffffff0 0 2
R B80 1 5 0 2
D B00 0 30
R B80 2 0 6 0
D B02 3 20
D B02 1 7

// File: compile.f
common/csr_pkg.sv
common/csr_bus_if.sv
logic/csr_access.sv
trap/trap_regs.sv
logic/csr_counters.sv
logic/csr_unit.sv
dv/csr_checker.sv
dv/tb_csr_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_csr_unit \
    -f compile.f \
    -o sim_csr_unit

./obj_dir/sim_csr_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "TB PASSED" sim.log; then
    exit 0
else
    exit 1
fi
